//--- gmii_tx_subsys.f
src/chan_pkg.sv
src/gmii_pkg.sv
src/stream_distributor.sv
src/chan_frame_buffer.sv
src/gmii_tx_arbiter.sv
src/gmii_tx_subsys.sv
test/tb_gmii_tx_subsys.sv

//--- Makefile
# Verilator flow for the GMII transmit subsystem
VERILATOR ?= verilator
TOP       ?= tb_gmii_tx_subsys
LINT_TOP  ?= gmii_tx_subsys
FILELIST  ?= gmii_tx_subsys.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "TB FAILED" $(LOG); then exit 1; fi

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(LINT_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- test/tb_gmii_tx_subsys.sv
`timescale 1ns/1ps

module tb_gmii_tx_subsys;

   typedef struct packed {
      logic [1:0]                  phase;   // Frames of one phase are loaded together
      logic [chan_pkg::CHAN_W-1:0] chan;
      logic [5:0]                  len;
      logic [7:0]                  first;
      logic [7:0]                  step;    // Increment between frame bytes
   } frame_t;

   localparam int NUM_FRAMES = 9;
   localparam int NUM_PHASES = 4;

   frame_t frames [NUM_FRAMES] = '{
      '{2'd0, 2'd2, 6'd4, 8'h40, 8'h11},
      '{2'd0, 2'd0, 6'd5, 8'h01, 8'h03},
      '{2'd0, 2'd3, 6'd9, 8'h80, 8'h07},
      '{2'd0, 2'd1, 6'd7, 8'h20, 8'h01},
      '{2'd1, 2'd1, 6'd6, 8'hA0, 8'h01},    // Single frame on channel 1
      '{2'd2, 2'd1, 6'd8, 8'hC3, 8'hFF},
      '{2'd2, 2'd0, 6'd3, 8'h30, 8'h05},
      '{2'd2, 2'd3, 6'd2, 8'h7E, 8'h02},    // Pointer sits at 2 here
      '{2'd3, 2'd2, 6'd32, 8'h00, 8'h09}    // Uses every credit of channel 2
   };

   logic               GMII_GTX_CLK_int;
   logic               arst_n_i;
   chan_pkg::in_byte_t in_i;
   logic               in_valid_i;
   logic               in_ready_o;
   logic [7:0]         gmii_txd_o;
   logic               gmii_tx_en_o;

   logic [7:0] exp_q [$];   // Expected GMII bytes in wire order
   int         len_q [$];   // Bytes per frame incl. preamble and SFD
   int         gap_q [$];   // Idle cycles before each frame or -1 when open
   int         seed = 32;
   int         checks = 0;
   int         value_errs = 0;
   int         other_errs = 0;
   int         cycles = 0;
   int         cycle_limit = 0;
   int         left = 0;
   int         idle = 0;
   int         gap;
   bit         mon_on = 1'b0;

   gmii_tx_subsys u_gmii_tx_subsys
   (
      .GMII_GTX_CLK_int (GMII_GTX_CLK_int),
      .arst_n_i         (arst_n_i),
      .in_i             (in_i),
      .in_valid_i       (in_valid_i),
      .in_ready_o       (in_ready_o),
      .gmii_txd_o       (gmii_txd_o),
      .gmii_tx_en_o     (gmii_tx_en_o)
   );

   initial
   begin
      GMII_GTX_CLK_int = 1'b0;
      forever #4 GMII_GTX_CLK_int = ~GMII_GTX_CLK_int;
   end

   function automatic logic [7:0] frame_byte(input frame_t f, input int j);
      logic [7:0] b;
      b = f.first + 8'(j) * f.step;
      return b;
   endfunction

   task automatic expect_frame(input frame_t f, input int gap_cycles);
      for (int k = 0; k < gmii_pkg::PREAMBLE_LEN; k++)
         exp_q.push_back(gmii_pkg::PREAMBLE_BYTE);
      exp_q.push_back(gmii_pkg::SFD_BYTE);
      for (int j = 0; j < int'(f.len); j++)
         exp_q.push_back(frame_byte(f, j));
      len_q.push_back(int'(f.len) + gmii_pkg::PREAMBLE_LEN + 1);
      gap_q.push_back(gap_cycles);
   endtask

   // Holds the byte until the DUT takes it
   task automatic send_byte(input logic [chan_pkg::CHAN_W-1:0] chan, input logic [7:0] data,
                            input logic last);
      @(negedge GMII_GTX_CLK_int);
      in_i.chan = chan;
      in_i.data = data;
      in_i.last = last;
      in_valid_i = 1'b1;
      #1;
      while (!in_ready_o)
      begin
         @(negedge GMII_GTX_CLK_int);
         #1;
      end
      @(posedge GMII_GTX_CLK_int);
   endtask

   task automatic check_ready(input logic [chan_pkg::CHAN_W-1:0] chan, input logic exp);
      @(negedge GMII_GTX_CLK_int);
      in_valid_i = 1'b0;
      in_i.chan = chan;
      #1;
      checks++;
      if (in_ready_o !== exp)
      begin
         $display("[ERROR] %0t in_ready_o (chan %0d) expected %b got %b",
                  $time, chan, exp, in_ready_o);
         value_errs++;
      end
   endtask

   // GMII monitor against the expected byte stream
   always @(negedge GMII_GTX_CLK_int)
   begin
      if (mon_on && gmii_tx_en_o)
      begin
         if (left == 0)
         begin
            if (len_q.size() == 0)
            begin
               $display("%0t: gmii_tx_en_o went high with no frame expected", $time);
               other_errs++;
            end
            else
            begin
               left = len_q.pop_front();
               gap = gap_q.pop_front();
               checks++;
               if (gap >= 0 && idle != gap)
               begin
                  $display("[ERROR] %0t gmii_tx_en_o low cycles expected %0d got %0d",
                           $time, gap, idle);
                  value_errs++;
               end
            end
         end
         if (left != 0)
         begin
            left--;
            checks++;
            if (gmii_txd_o !== exp_q[0])
            begin
               $display("[ERROR] %0t gmii_txd_o expected %h got %h", $time, exp_q[0], gmii_txd_o);
               value_errs++;
            end
            void'(exp_q.pop_front());
         end
         idle = 0;
      end
      else if (mon_on)
      begin
         if (left != 0)
         begin
            $display("%0t: frame on GMII ended %0d bytes early", $time, left);
            other_errs++;
            for (int k = 0; k < left; k++)
               void'(exp_q.pop_front());
            left = 0;
         end
         idle++;
      end
   end

   always @(posedge GMII_GTX_CLK_int)
   begin
      cycles++;
      if (cycles > cycle_limit)
      begin
         $display("Timeout after %0d cycles while waiting for GMII output", cycles);
         $display("TB FAILED");
         $finish;
      end
   end

   initial
   begin
      int     order [$];
      int     ptr;
      int     total;
      frame_t f;
      in_i = '0;
      in_valid_i = 1'b0;
      arst_n_i = 1'b0;
      total = 0;
      foreach (frames[i])
         total += int'(frames[i].len);
      cycle_limit = total + 20 * NUM_FRAMES + 200;   // Table bytes, per-frame overhead, margin
      repeat (3) @(posedge GMII_GTX_CLK_int);
      @(negedge GMII_GTX_CLK_int);
      arst_n_i = 1'b1;
      mon_on = 1'b1;

      // Idle outputs and full credits after reset
      for (int c = 0; c < chan_pkg::NUM_CHAN; c++)
      begin
         check_ready(chan_pkg::CHAN_W'(c), 1'b1);
         checks++;
         if (gmii_tx_en_o !== 1'b0 || gmii_txd_o !== 8'h00)
         begin
            $display("[ERROR] %0t gmii_tx_en_o/gmii_txd_o expected 0/00 got %b/%h",
                     $time, gmii_tx_en_o, gmii_txd_o);
            value_errs++;
         end
      end

      ptr = 0;
      for (int p = 0; p < NUM_PHASES; p++)
      begin
         order.delete();
         for (int k = 0; k < chan_pkg::NUM_CHAN; k++)   // Round-robin from pointer
            foreach (frames[i])
               if (int'(frames[i].phase) == p &&
                   int'(frames[i].chan) == (ptr + k) % chan_pkg::NUM_CHAN)
                  order.push_back(i);
         foreach (order[n])
            expect_frame(frames[order[n]], (n == 0) ? -1 : gmii_pkg::IFG_LEN);
         ptr = (int'(frames[order[$]].chan) + 1) % chan_pkg::NUM_CHAN;

         // Frame bodies first so that all frames complete within a few cycles
         foreach (order[n])
         begin
            f = frames[order[n]];
            for (int j = 0; j < int'(f.len) - 1; j++)
            begin
               if ($random(seed) & 1)
               begin
                  @(negedge GMII_GTX_CLK_int);
                  in_valid_i = 1'b0;
               end
               send_byte(f.chan, frame_byte(f, j), 1'b0);
            end
         end

         // Pointer's pick closes first, the others in reverse of the send order
         for (int n = 0; n < order.size(); n++)
         begin
            f = frames[order[(n == 0) ? 0 : order.size() - n]];
            send_byte(f.chan, frame_byte(f, int'(f.len) - 1), 1'b1);
            check_ready(f.chan, int'(f.len) != chan_pkg::CHAN_DEPTH);   // No credit left when full
         end
         while (exp_q.size() != 0)
            @(negedge GMII_GTX_CLK_int);
         repeat (gmii_pkg::IFG_LEN + 2) @(negedge GMII_GTX_CLK_int);
      end

      if (len_q.size() != 0)
      begin
         $display("%0d frames were never transmitted", len_q.size());
         other_errs++;
      end
      $display("Checks: %0d, value errors: %0d, other errors: %0d",
               checks, value_errs, other_errs);
      if (value_errs + other_errs == 0)
         $display("TB PASSED");
      else
         $display("TB FAILED");
      $finish;
   end

endmodule

//--- src/gmii_tx_subsys.sv
`timescale 1ns/1ps

module gmii_tx_subsys
(
   input  logic               GMII_GTX_CLK_int,
   input  logic               arst_n_i,
   input  chan_pkg::in_byte_t in_i,
   input  logic               in_valid_i,
   output logic               in_ready_o,
   output logic [7:0]         gmii_txd_o,
   output logic               gmii_tx_en_o
);

   logic [chan_pkg::NUM_CHAN-1:0]                push;
   logic [chan_pkg::NUM_CHAN-1:0]                credit_ret;
   logic [chan_pkg::NUM_CHAN-1:0]                frame_ready;
   logic [chan_pkg::NUM_CHAN-1:0]                pop;
   chan_pkg::buf_word_t                          push_word;   // Shared by all buffers
   chan_pkg::buf_word_t [chan_pkg::NUM_CHAN-1:0] head;

   stream_distributor u_stream_distributor
   (
      .GMII_GTX_CLK_int (GMII_GTX_CLK_int),
      .arst_n_i         (arst_n_i),
      .in_i             (in_i),
      .in_valid_i       (in_valid_i),
      .in_ready_o       (in_ready_o),
      .credit_ret_i     (credit_ret),
      .push_o           (push),
      .push_word_o      (push_word)
   );

   for (genvar i = 0; i < chan_pkg::NUM_CHAN; i++)
   begin : g_chan
      chan_frame_buffer u_chan_frame_buffer
      (
         .GMII_GTX_CLK_int (GMII_GTX_CLK_int),
         .arst_n_i         (arst_n_i),
         .push_i           (push[i]),
         .push_word_i      (push_word),
         .pop_i            (pop[i]),
         .head_o           (head[i]),
         .frame_ready_o    (frame_ready[i]),
         .credit_ret_o     (credit_ret[i])
      );
   end

   gmii_tx_arbiter u_gmii_tx_arbiter
   (
      .GMII_GTX_CLK_int (GMII_GTX_CLK_int),
      .arst_n_i         (arst_n_i),
      .frame_ready_i    (frame_ready),
      .head_i           (head),
      .pop_o            (pop),
      .gmii_txd_o       (gmii_txd_o),
      .gmii_tx_en_o     (gmii_tx_en_o)
   );

endmodule

//--- src/gmii_tx_arbiter.sv
`timescale 1ns/1ps

module gmii_tx_arbiter
(
   input  logic                                          GMII_GTX_CLK_int,
   input  logic                                          arst_n_i,
   input  logic [chan_pkg::NUM_CHAN-1:0]                 frame_ready_i,
   input  chan_pkg::buf_word_t [chan_pkg::NUM_CHAN-1:0]  head_i,
   output logic [chan_pkg::NUM_CHAN-1:0]                 pop_o,
   output logic [7:0]                                    gmii_txd_o,
   output logic                                          gmii_tx_en_o
);

   gmii_pkg::tx_state_t              state;
   logic [gmii_pkg::PRE_CNT_W-1:0]   pre_cnt;
   logic [gmii_pkg::IFG_CNT_W-1:0]   ifg_cnt;
   logic [chan_pkg::CHAN_W-1:0]      sel;        // Channel being sent
   logic [chan_pkg::CHAN_W-1:0]      rr_ptr;     // First channel to look at next
   logic [chan_pkg::CHAN_W-1:0]      cand;
   logic [chan_pkg::CHAN_W-1:0]      pick_chan;
   logic                             pick_found;
   logic                             pre_last;
   logic                             ifg_last;
   logic                             start;
   logic [7:0]                       txd_unreg;
   logic                             tx_en_unreg;

   assign pre_last = (pre_cnt == gmii_pkg::PRE_CNT_W'(gmii_pkg::PREAMBLE_LEN - 1));
   assign ifg_last = (ifg_cnt == gmii_pkg::IFG_CNT_W'(gmii_pkg::IFG_LEN - 1));

   // Round-robin search from rr_ptr
   always_comb
   begin
      pick_found = 1'b0;
      pick_chan = rr_ptr;
      cand = rr_ptr;
      for (int i = 0; i < chan_pkg::NUM_CHAN; i++)
      begin
         cand = rr_ptr + chan_pkg::CHAN_W'(i);
         if (!pick_found && frame_ready_i[cand])
         begin
            pick_found = 1'b1;
            pick_chan = cand;
         end
      end
   end

   // Last IFG cycle doubles as the idle decision
   assign start = pick_found &&
                  (state == gmii_pkg::TX_IDLE || (state == gmii_pkg::TX_IFG && ifg_last));

   always_comb
   begin
      pop_o = '0;
      txd_unreg = 8'h00;
      tx_en_unreg = 1'b0;
      case (state)
         gmii_pkg::TX_PREAMBLE:
         begin
            txd_unreg = gmii_pkg::PREAMBLE_BYTE;
            tx_en_unreg = 1'b1;
         end
         gmii_pkg::TX_SFD:
         begin
            txd_unreg = gmii_pkg::SFD_BYTE;
            tx_en_unreg = 1'b1;
         end
         gmii_pkg::TX_DATA:
         begin
            txd_unreg = head_i[sel].data;
            tx_en_unreg = 1'b1;
            pop_o[sel] = 1'b1;   // One byte per cycle from a complete frame
         end
         default: ;
      endcase
   end

   always_ff @(posedge GMII_GTX_CLK_int or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         state <= gmii_pkg::TX_IDLE;
         pre_cnt <= '0;
         ifg_cnt <= '0;
         sel <= '0;
         rr_ptr <= '0;
      end
      else if (start)
      begin
         state <= gmii_pkg::TX_PREAMBLE;
         sel <= pick_chan;
         rr_ptr <= pick_chan + 1'b1;
         pre_cnt <= '0;
      end
      else
      begin
         case (state)
            gmii_pkg::TX_PREAMBLE:
            begin
               if (pre_last)
                  state <= gmii_pkg::TX_SFD;
               else
                  pre_cnt <= pre_cnt + 1'b1;
            end
            gmii_pkg::TX_SFD: state <= gmii_pkg::TX_DATA;
            gmii_pkg::TX_DATA:
            begin
               if (head_i[sel].last)
               begin
                  state <= gmii_pkg::TX_IFG;
                  ifg_cnt <= '0;
               end
            end
            gmii_pkg::TX_IFG:
            begin
               if (ifg_last)
                  state <= gmii_pkg::TX_IDLE;   // Nothing waiting
               else
                  ifg_cnt <= ifg_cnt + 1'b1;
            end
            default: ;
         endcase
      end
   end

   // Output register stage
   always_ff @(posedge GMII_GTX_CLK_int or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         gmii_txd_o <= 8'h00;
         gmii_tx_en_o <= 1'b0;
      end
      else
      begin
         gmii_txd_o <= txd_unreg;
         gmii_tx_en_o <= tx_en_unreg;
      end
   end

   // Selected buffer keeps its frame until the last byte leaves
   a_data_ready: assert property (@(posedge GMII_GTX_CLK_int) disable iff (!arst_n_i)
      state == gmii_pkg::TX_DATA |-> frame_ready_i[sel]);

endmodule

//--- src/chan_frame_buffer.sv
`timescale 1ns/1ps

module chan_frame_buffer
(
   input  logic                GMII_GTX_CLK_int,
   input  logic                arst_n_i,
   input  logic                push_i,
   input  chan_pkg::buf_word_t push_word_i,
   input  logic                pop_i,
   output chan_pkg::buf_word_t head_o,
   output logic                frame_ready_o,
   output logic                credit_ret_o
);

   chan_pkg::buf_word_t mem [chan_pkg::CHAN_DEPTH];

   // Extra top bit tells full from empty
   logic [chan_pkg::PTR_W:0]    wr_ptr;
   logic [chan_pkg::PTR_W:0]    rd_ptr;
   logic [chan_pkg::CRED_W-1:0] frame_cnt;   // Complete frames stored
   logic                        empty;

   assign empty = (wr_ptr == rd_ptr);
   assign head_o = mem[rd_ptr[chan_pkg::PTR_W-1:0]];
   assign frame_ready_o = (frame_cnt != '0);

   // Storage
   always_ff @(posedge GMII_GTX_CLK_int)
   begin
      if (push_i)
         mem[wr_ptr[chan_pkg::PTR_W-1:0]] <= push_word_i;
   end

   always_ff @(posedge GMII_GTX_CLK_int or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         frame_cnt <= '0;
         credit_ret_o <= 1'b0;
      end
      else
      begin
         if (push_i)
            wr_ptr <= wr_ptr + 1'b1;
         if (pop_i)
            rd_ptr <= rd_ptr + 1'b1;

         // Frame closed on write, released on read of its last byte
         case ({push_i && push_word_i.last, pop_i && head_o.last})
            2'b10: frame_cnt <= frame_cnt + 1'b1;
            2'b01: frame_cnt <= frame_cnt - 1'b1;
            default: ;
         endcase

         credit_ret_o <= pop_i;   // One slot freed
      end
   end

   // Arbiter only drains whole frames
   a_no_pop_empty: assert property (@(posedge GMII_GTX_CLK_int) disable iff (!arst_n_i)
      pop_i |-> !empty);

endmodule

//--- src/stream_distributor.sv
`timescale 1ns/1ps

module stream_distributor
(
   input  logic                            GMII_GTX_CLK_int,
   input  logic                            arst_n_i,
   input  chan_pkg::in_byte_t              in_i,
   input  logic                            in_valid_i,
   output logic                            in_ready_o,
   input  logic [chan_pkg::NUM_CHAN-1:0]   credit_ret_i,
   output logic [chan_pkg::NUM_CHAN-1:0]   push_o,
   output chan_pkg::buf_word_t             push_word_o
);

   logic [chan_pkg::CRED_W-1:0] credit [chan_pkg::NUM_CHAN];
   logic [chan_pkg::CRED_W-1:0] frame_len [chan_pkg::NUM_CHAN];   // Bytes so far in open frame

   // Ready only if the addressed buffer has room
   assign in_ready_o = (credit[in_i.chan] != '0);

   always_comb
   begin
      push_o = '0;
      if (in_valid_i && in_ready_o)
         push_o[in_i.chan] = 1'b1;
      push_word_o.data = in_i.data;
      push_word_o.last = in_i.last;
   end

   always_ff @(posedge GMII_GTX_CLK_int or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         for (int c = 0; c < chan_pkg::NUM_CHAN; c++)
         begin
            credit[c] <= chan_pkg::CRED_W'(chan_pkg::CHAN_DEPTH);   // All buffers empty
            frame_len[c] <= '0;
         end
      end
      else
      begin
         for (int c = 0; c < chan_pkg::NUM_CHAN; c++)
         begin
            // Push and return in one cycle cancel out
            case ({push_o[c], credit_ret_i[c]})
               2'b10: credit[c] <= credit[c] - 1'b1;
               2'b01: credit[c] <= credit[c] + 1'b1;
               default: ;
            endcase

            if (push_o[c])
            begin
               if (in_i.last)
                  frame_len[c] <= '0;
               else
                  frame_len[c] <= frame_len[c] + 1'b1;
            end
         end
      end
   end

   for (genvar c = 0; c < chan_pkg::NUM_CHAN; c++)
   begin : g_chk
      // Buffers never hand back more credits than were taken
      a_credit_max: assert property (@(posedge GMII_GTX_CLK_int) disable iff (!arst_n_i)
         credit[c] <= chan_pkg::CRED_W'(chan_pkg::CHAN_DEPTH));

      // A frame must fit in one buffer
      a_frame_len: assert property (@(posedge GMII_GTX_CLK_int) disable iff (!arst_n_i)
         push_o[c] |-> frame_len[c] < chan_pkg::CRED_W'(chan_pkg::CHAN_DEPTH));
   end

endmodule

//--- src/gmii_pkg.sv
package gmii_pkg;

   // Frame start bytes
   localparam logic [7:0] PREAMBLE_BYTE = 8'h55;
   localparam logic [7:0] SFD_BYTE = 8'hD5;

   localparam int PREAMBLE_LEN = 7;
   localparam int PRE_CNT_W = 3;

   // Inter-frame gap in byte times
   localparam int IFG_LEN = 12;
   localparam int IFG_CNT_W = 4;

   // Transmit FSM
   typedef enum logic [2:0] {
      TX_IDLE,
      TX_PREAMBLE,
      TX_SFD,
      TX_DATA,
      TX_IFG
   } tx_state_t;

endpackage

//--- src/chan_pkg.sv
package chan_pkg;

   // Channel count and widths
   localparam int NUM_CHAN = 4;
   localparam int CHAN_W = 2;

   // Buffer depth, also the initial credit count and the longest frame
   localparam int CHAN_DEPTH = 32;
   localparam int PTR_W = 5;          // FIFO address bits
   localparam int CRED_W = 6;         // Holds 0 to CHAN_DEPTH

   // Byte as it arrives from the core
   typedef struct packed {
      logic [CHAN_W-1:0] chan;
      logic [7:0]        data;
      logic              last;        // Final byte of a frame
   } in_byte_t;

   // One FIFO entry
   typedef struct packed {
      logic [7:0] data;
      logic       last;
   } buf_word_t;

endpackage
